// File: hw/rv_core_pkg.sv
package rv_core_pkg;

    // data path width, RV32I only
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;     // register / data word
    typedef logic [31:0]     instr_t;    // instruction word, always 32 bit
    typedef logic [4:0]      reg_addr_t; // register index, 5 bit field in the encoding
    typedef logic [3:0]      alu_op_t;   // ALU operation select

    // ALU operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10; // passes the U immediate

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // decoder output, consumed by the ALU and the write-back register
    typedef struct packed {
        alu_op_t   alu_op;  // operation
        reg_addr_t rd;      // destination index
        logic      rd_we;   // legal and rd != 0
        logic      use_imm; // operand b from imm
        word_t     imm;     // sign-extended I or shifted U immediate
        logic      illegal; // unknown encoding or register out of range
    } dec_t;

    // write-back stage, also the result output of the top level
    typedef struct packed {
        logic      valid; // register file write this cycle
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

// File: hw/reg_file.sv
module reg_file
    import rv_core_pkg::*;
#(
    parameter int REG_NUM = 32 // 32 for RV32I, 16 for RV32E
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // core write port, from the write-back stage
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,

    // debug port
    input  logic      dbg_we_i,
    input  reg_addr_t dbg_addr_i,
    input  word_t     dbg_data_i,

    // source operand read ports
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,

    output word_t     rdata1_o,
    output word_t     rdata2_o,
    output word_t     dbg_data_o // current contents, no forwarding
);

    word_t regs_q [REG_NUM]; // x0 slot exists but is never written or read

    // stored value, zero for x0 and for indices past the register set
    function automatic word_t stored_word(input reg_addr_t addr);
        if (addr == '0 || addr >= REG_NUM) begin
            return '0;
        end
        return regs_q[addr];
    endfunction

    // read with bypass of the pending write-back
    function automatic word_t core_read(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (waddr_i == addr)) begin
            return wdata_i; // dependent instruction right behind the writer
        end
        return stored_word(addr);
    endfunction

    // core port has priority, debug write only when the core is idle
    always_ff @(posedge clk_i) begin
        if (rst_n_i) begin
            if (we_i && waddr_i != '0 && waddr_i < REG_NUM) begin
                regs_q[waddr_i] <= wdata_i;
            end else if (dbg_we_i && dbg_addr_i != '0 && dbg_addr_i < REG_NUM) begin
                regs_q[dbg_addr_i] <= dbg_data_i;
            end
        end
    end

    always_comb begin
        rdata1_o = core_read(raddr1_i);
        rdata2_o = core_read(raddr2_i);
    end

    assign dbg_data_o = stored_word(dbg_addr_i); // debug sees storage only

endmodule

// File: hw/instr_decoder.sv
module instr_decoder
    import rv_core_pkg::*;
#(
    parameter int REG_NUM = 32
) (
    input  instr_t instr_i,
    output dec_t   dec_o
);

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    always_comb begin
        dec_o         = '0;
        dec_o.rd      = rd;
        dec_o.alu_op  = ALU_ADD;
        dec_o.illegal = rd >= REG_NUM; // rd checked for every format

        case (opcode)
            OPC_OP_IMM: begin
                dec_o.use_imm = 1'b1;
                dec_o.imm     = {{20{instr_i[31]}}, instr_i[31:20]}; // I-type, sign-extended
                if (rs1 >= REG_NUM) dec_o.illegal = 1'b1;
                case (funct3)
                    3'b000: dec_o.alu_op = ALU_ADD;
                    3'b010: dec_o.alu_op = ALU_SLT;
                    3'b011: dec_o.alu_op = ALU_SLTU;
                    3'b100: dec_o.alu_op = ALU_XOR;
                    3'b110: dec_o.alu_op = ALU_OR;
                    3'b111: dec_o.alu_op = ALU_AND;
                    3'b001: begin
                        dec_o.alu_op = ALU_SLL;
                        if (funct7 != 7'b0000000) dec_o.illegal = 1'b1; // slli only
                    end
                    default: begin // 3'b101, srli or srai
                        dec_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        if ((funct7 & 7'b1011111) != 7'b0000000) dec_o.illegal = 1'b1;
                    end
                endcase
            end
            OPC_OP: begin
                if (rs1 >= REG_NUM || rs2 >= REG_NUM) dec_o.illegal = 1'b1;
                // funct7[5] only legal on add/sub and srl/sra
                if ((funct7 & 7'b1011111) != 7'b0000000) dec_o.illegal = 1'b1;
                if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101) dec_o.illegal = 1'b1;
                case (funct3)
                    3'b000:  dec_o.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec_o.alu_op = ALU_SLL;
                    3'b010:  dec_o.alu_op = ALU_SLT;
                    3'b011:  dec_o.alu_op = ALU_SLTU;
                    3'b100:  dec_o.alu_op = ALU_XOR;
                    3'b101:  dec_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec_o.alu_op = ALU_OR;
                    default: dec_o.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                dec_o.alu_op  = ALU_LUI;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = {instr_i[31:12], 12'b0}; // U-type
            end
            default: dec_o.illegal = 1'b1; // loads, branches etc not in this slice
        endcase

        dec_o.rd_we = !dec_o.illegal && (rd != '0); // x0 writes dropped here
    end

endmodule

// File: hw/int_alu.sv
module int_alu
    import rv_core_pkg::*;
(
    input  dec_t  dec_i,      // operation, immediate and operand select
    input  word_t rs1_data_i, // forwarded source 1
    input  word_t rs2_data_i, // forwarded source 2
    output word_t result_o
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;       // RV32 shifts use the low 5 bits only
    word_t      sum;
    word_t      diff;
    logic       lt_signed;
    logic       lt_unsigned;
    word_t      shl;
    word_t      shr_logic;
    word_t      shr_arith;

    assign op_a = rs1_data_i;

    // second operand, immediate for OP-IMM and LUI
    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    // adder and subtractor
    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // compares
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // shifter
    assign shl       = op_a << shamt;
    assign shr_logic = op_a >> shamt;
    assign shr_arith = word_t'($signed(op_a) >>> shamt); // sign fills from the top

    // result mux
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD: begin
                result_o = sum;
            end
            ALU_SUB: begin
                result_o = diff;
            end
            ALU_SLL: begin
                result_o = shl;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result_o = op_a ^ op_b;
            end
            ALU_SRL: begin
                result_o = shr_logic;
            end
            ALU_SRA: begin
                result_o = shr_arith;
            end
            ALU_OR: begin
                result_o = op_a | op_b;
            end
            ALU_AND: begin
                result_o = op_a & op_b;
            end
            ALU_LUI: begin
                result_o = dec_i.imm; // upper immediate, low 12 bits already zero
            end
            default: begin
                result_o = '0; // unused codes, never issued by the decoder
            end
        endcase
    end

endmodule

// File: hw/op_exec_top.sv
module op_exec_top
    import rv_core_pkg::*;
#(
    parameter int REG_NUM = 32 // passed to register file and decoder
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // instruction strobe
    input  logic      instr_valid_i,
    input  instr_t    instr_i,

    // debug access to the register file
    input  logic      dbg_we_i,
    input  reg_addr_t dbg_addr_i,
    input  word_t     dbg_data_i,
    output word_t     dbg_data_o,

    // results, one cycle after the strobe
    output wb_t       wb_o,
    output logic      illegal_o
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    dec_t      dec;
    word_t     alu_result;
    wb_t       wb_q;       // write-back stage
    logic      illegal_q;  // one-cycle illegal pulse

    // source fields go straight to the register file, decode runs alongside
    assign rs1_addr = instr_i[19:15];
    assign rs2_addr = instr_i[24:20];

    reg_file #(
        .REG_NUM(REG_NUM)
    ) u_reg_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_q.valid), // write lands on the edge after write-back
        .waddr_i   (wb_q.rd),
        .wdata_i   (wb_q.data),
        .dbg_we_i  (dbg_we_i),
        .dbg_addr_i(dbg_addr_i),
        .dbg_data_i(dbg_data_i),
        .raddr1_i  (rs1_addr),
        .raddr2_i  (rs2_addr),
        .rdata1_o  (rs1_data),
        .rdata2_o  (rs2_data),
        .dbg_data_o(dbg_data_o)
    );

    instr_decoder #(
        .REG_NUM(REG_NUM)
    ) u_instr_decoder (
        .instr_i(instr_i),
        .dec_o  (dec)
    );

    int_alu u_int_alu (
        .dec_i     (dec),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .result_o  (alu_result)
    );

    // write-back register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            wb_q.valid <= instr_valid_i && dec.rd_we && !dec.illegal;
            illegal_q  <= instr_valid_i && dec.illegal; // pulse, no write
        end
        // payload follows the strobe
        if (instr_valid_i) begin
            wb_q.rd   <= dec.rd;
            wb_q.data <= alu_result;
        end
    end

    assign wb_o      = wb_q;
    assign illegal_o = illegal_q;

endmodule

// File: bench/op_exec_assert.sv
module op_exec_assert
    import rv_core_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,
    input logic instr_valid_i,
    input wb_t  wb_i,      // write-back stage of the top level
    input logic illegal_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // reset clears both result flags
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !wb_i.valid && !illegal_i)
        else $error("result flags not cleared by reset");

    // an instruction either writes back or is illegal, never both
    a_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wb_i.valid && illegal_i))
        else $error("wb valid and illegal high together");

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.valid |-> wb_i.rd != '0)
        else $error("write-back to x0");

    // fixed one cycle latency from the strobe
    a_wb_after_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.valid |-> $past(instr_valid_i))
        else $error("write-back without a strobe one cycle earlier");

endmodule

bind op_exec_top op_exec_assert u_op_exec_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .wb_i         (wb_o),
    .illegal_i    (illegal_o)
);

// File: bench/op_exec_tb.sv
module op_exec_tb
    import rv_core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_MIX  = 60; // phase 2 instructions
    localparam int N_FWD  = 40; // phase 3 pairs
    localparam int N_ILL  = 20;
    localparam int N_X0   = 20;
    localparam int N_COLL = 12;
    localparam int MAX_CYCLES = 2000; // all phases take about 520 cycles

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      instr_valid_i;
    instr_t    instr_i;
    logic      dbg_we_i;
    reg_addr_t dbg_addr_i;
    word_t     dbg_data_i;
    word_t     dbg_data_o;
    wb_t       wb_o;
    logic      illegal_o;

    word_t     model_regs [32]; // register contents as the DUT should hold them
    wb_t       exp_wb;          // write-back the DUT should show now
    logic      exp_ill;
    int        wb_errs   = 0;
    int        word_errs = 0;
    int        flag_errs = 0;
    int        cycle_cnt = 0;
    instr_t    ins;
    reg_addr_t r;
    word_t     d;

    op_exec_top #(
        .REG_NUM(32)
    ) uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .dbg_we_i     (dbg_we_i),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_data_i   (dbg_data_i),
        .dbg_data_o   (dbg_data_o),
        .wb_o         (wb_o),
        .illegal_o    (illegal_o)
    );

    always #4 clk_i = ~clk_i; // 8 ns period

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_wb(input wb_t act, input wb_t exp);
        // rd and data only matter with valid set
        if (act.valid !== exp.valid ||
            (exp.valid && (act.rd !== exp.rd || act.data !== exp.data))) begin
            $write("mismatch at %0t: wb_o expected valid=%b rd=%0d data=%h", $time,
                   exp.valid, exp.rd, exp.data);
            $display(", actual valid=%b rd=%0d data=%h", act.valid, act.rd, act.data);
            wb_errs++;
        end
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (!$isunknown(exp) && act !== exp) begin // unknown = never written yet
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            word_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            flag_errs++;
        end
    endtask

    // operand as the core sees it, pending write-back bypassed
    function automatic word_t forwarded_reg(input reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        if (exp_wb.valid && exp_wb.rd == a) begin
            return exp_wb.data;
        end
        return model_regs[a];
    endfunction

    // reference decode and execute, straight from the RV32I encoding
    function automatic void expected_result(input instr_t i, output logic ill,
                                            output word_t res);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;  // sub or sra
        word_t      a;
        word_t      b;
        f3  = i[14:12];
        f7  = i[31:25];
        a   = forwarded_reg(i[19:15]);
        ill = 1'b0;
        res = '0;
        if (i[6:0] == OPC_LUI) begin
            res = {i[31:12], 12'h000};
            return;
        end
        if (i[6:0] == OPC_OP_IMM) begin
            b   = {{20{i[31]}}, i[31:20]};
            alt = (f3 == 3'b101) && f7[5];
            if (f3 == 3'b001 && f7 != 7'h00) ill = 1'b1;
            if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) ill = 1'b1;
        end else if (i[6:0] == OPC_OP) begin
            b   = forwarded_reg(i[24:20]);
            alt = f7[5];
            if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) ill = 1'b1;
        end else begin
            ill = 1'b1; // outside this slice
            return;
        end
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) res = $signed(a) >>> b[4:0]; // sign fills from the top
                else res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
    endfunction

    // one clock cycle, entered and left at a falling edge
    task automatic run_cycle(input logic v, input instr_t i, input logic dwe,
                             input reg_addr_t da, input word_t dd);
        wb_t   nxt_wb;
        logic  nxt_ill;
        word_t res;
        check_wb(wb_o, exp_wb); // results of the last rising edge
        check_flag("illegal_o", illegal_o, exp_ill);
        instr_valid_i = v;
        instr_i       = i;
        dbg_we_i      = dwe;
        dbg_addr_i    = da;
        dbg_data_i    = dd;
        expected_result(i, nxt_ill, res);
        nxt_wb.valid = v && !nxt_ill && i[11:7] != '0;
        nxt_wb.rd    = i[11:7];
        nxt_wb.data  = res;
        #2;
        check_word("dbg_data_o", dbg_data_o, (da == '0) ? '0 : model_regs[da]);
        @(posedge clk_i);
        if (exp_wb.valid) model_regs[exp_wb.rd] = exp_wb.data; // core write wins
        else if (dwe && da != '0) model_regs[da] = dd;
        exp_wb  = nxt_wb;
        exp_ill = v && nxt_ill;
        @(negedge clk_i);
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic issue(input instr_t i);
        run_cycle(1'b1, i, 1'b0, '0, '0);
    endtask

    task automatic debug_write(input reg_addr_t a, input word_t v);
        run_cycle(1'b0, '0, 1'b1, a, v);
    endtask

    task automatic debug_read(input reg_addr_t a);
        run_cycle(1'b0, '0, 1'b0, a, '0);
    endtask

    // legal instruction, kind 0 OP-IMM, 1 OP, 2 LUI
    function automatic instr_t rand_instr(input int kind, input reg_addr_t rd);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        f3  = 3'($urandom);
        f7  = 7'h00;
        imm = 12'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        if (kind == 2) return {20'($urandom), rd, OPC_LUI};
        if (f3 == 3'b101 || (kind == 1 && f3 == 3'b000)) f7[5] = 1'($urandom);
        if (kind == 1) return {f7, rs2, rs1, f3, rd, OPC_OP};
        if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = f7; // shift amount form
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t illegal_instr(input reg_addr_t rd);
        instr_t     i;
        logic [6:0] f7;
        i       = $urandom;
        i[11:7] = rd;
        f7      = 7'($urandom);
        f7[$urandom_range(4, 0)] = 1'b1; // some bit other than 5
        case ($urandom_range(2, 0))
            0: begin
                while (i[6:0] == OPC_OP_IMM || i[6:0] == OPC_OP || i[6:0] == OPC_LUI) begin
                    i[6:0] = 7'($urandom);
                end
            end
            1: begin
                i[31:25] = f7;
                i[6:0]   = OPC_OP;
            end
            default: begin // slli with a bad funct7
                i[31:25] = f7;
                i[14:12] = 3'b001;
                i[6:0]   = OPC_OP_IMM;
            end
        endcase
        return i;
    endfunction

    initial begin
        void'($urandom(32'h1bb5fe91));
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        dbg_we_i      = 1'b0;
        dbg_addr_i    = '0;
        dbg_data_i    = '0;
        model_regs[0] = '0;
        exp_wb        = '0;
        exp_ill       = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // 1: quiet after reset, then fill every register over debug
        idle(3);
        for (int a = 1; a < 32; a++) debug_write(reg_addr_t'(a), $urandom);
        debug_write('0, $urandom);
        for (int a = 0; a < 32; a++) debug_read(reg_addr_t'(a));

        // 2: independent mix with gaps
        for (int n = 0; n < N_MIX; n++) begin
            issue(rand_instr($urandom_range(2, 0), 5'($urandom)));
            idle(1);
        end

        // 3: second instruction reads the first one's rd
        for (int n = 0; n < N_FWD; n++) begin
            r = reg_addr_t'($urandom_range(31, 1));
            issue(rand_instr($urandom_range(2, 0), r));
            ins = rand_instr($urandom_range(1, 0), reg_addr_t'($urandom_range(31, 1)));
            if (ins[6:0] == OPC_OP && $urandom_range(1, 0) == 1) ins[24:20] = r;
            else ins[19:15] = r;
            issue(ins);
            idle(1);
        end

        // 4: illegal pulse, register left alone
        for (int n = 0; n < N_ILL; n++) begin
            r = reg_addr_t'($urandom_range(31, 1));
            issue(illegal_instr(r));
            debug_read(r);
            idle(1);
        end

        // 5: rd = 0 drops the write, x0 operand right behind it
        for (int n = 0; n < N_X0; n++) begin
            issue(rand_instr($urandom_range(2, 0), '0));
            ins = rand_instr(1, reg_addr_t'($urandom_range(31, 1)));
            if (n % 2 == 0) ins[19:15] = '0;
            else ins[24:20] = '0;
            issue(ins);
            idle(1);
        end

        // 6: debug write during an active write-back, same and other address
        for (int n = 0; n < N_COLL; n++) begin
            r = reg_addr_t'($urandom_range(31, 1));
            d = $urandom;
            issue(rand_instr($urandom_range(2, 0), r));
            if (n % 2 == 0) debug_write(r, d);
            else debug_write(reg_addr_t'((r - 1 + $urandom_range(30, 1)) % 31 + 1), d);
            idle(1);
        end
        for (int a = 0; a < 32; a++) debug_read(reg_addr_t'(a));
        idle(1);

        $display("errors: wb_o %0d, dbg_data_o %0d, illegal_o %0d",
                 wb_errs, word_errs, flag_errs);
        if (wb_errs + word_errs + flag_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hw/rv_core_pkg.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/int_alu.sv
hw/op_exec_top.sv
bench/op_exec_assert.sv
bench/op_exec_tb.sv
